// File: design/fma_pkg.sv
package fma_pkg;

    // ------------------------------------------------------------------
    // Word layout
    // ------------------------------------------------------------------
    localparam int FP_W     = 64;
    localparam int EXP_W    = 11;
    localparam int FRAC_W   = 52;
    localparam int EXP_BIAS = 1023;
    localparam int EXP_MAX  = 2047;

    // ------------------------------------------------------------------
    // Datapath widths
    // ------------------------------------------------------------------
    // Mantissa slice for the 17x17 multipliers
    localparam int PP_W    = 17;
    // Product mantissa with the lowest slice dropped
    localparam int PROD_W  = 89;
    // Signed add path, two integer bits above the hidden bit
    localparam int ALIGN_W = 56;
    localparam int MAG_W   = 55;
    localparam int LZC_W   = 6;

    // Binary64 operand or result
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp64_t;

    // Stage 4 output, last tree level still pending
    typedef struct packed {
        logic              valid;
        logic              error;
        logic              sign;
        // Biased exponent of a*b
        logic [EXP_W-1:0]  exp;
        logic [PROD_W-1:0] psum0;
        logic [PROD_W-1:0] psum1;
    } mult_out_t;

    // Stage 6 output, both terms on a common exponent
    typedef struct packed {
        logic                      valid;
        logic                      error;
        logic [EXP_W-1:0]          exp;
        logic signed [ALIGN_W-1:0] term_p;
        logic signed [ALIGN_W-1:0] term_c;
    } align_out_t;

    // Stage 10 output, hidden bit at the top of mag
    typedef struct packed {
        logic             valid;
        logic             error;
        logic             sign;
        logic [EXP_W-1:0] exp;
        logic [MAG_W-1:0] mag;
    } norm_out_t;

endpackage

// File: design/fma_lzc.sv
`timescale 1ns/100ps

module fma_lzc (
    input  logic [fma_pkg::MAG_W-1:0] mag,
    output logic [fma_pkg::LZC_W-1:0] count
);
    import fma_pkg::*;

    // ------------------------------------------------------------------
    // Priority encoder on the leading one
    // ------------------------------------------------------------------
    // Scan from the LSB so the highest set bit wins
    always_comb begin
        // All zero reads as a full-width count
        count = LZC_W'(MAG_W);
        for (int i = 0; i < MAG_W; i++) begin
            if (mag[i]) begin
                count = LZC_W'(MAG_W - 1 - i);
            end
        end
    end

endmodule

// File: design/fma_mant_mult.sv
`timescale 1ns/100ps

module fma_mant_mult (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  fma_pkg::fp64_t     a,
    input  fma_pkg::fp64_t     b,
    output fma_pkg::mult_out_t mult
);
    import fma_pkg::*;

    // Unbiased sum check needs one extra bit
    logic [EXP_W:0]      exp_sum;
    logic                exp_bad;

    // Sideband, index n is stage n+1
    logic [3:0]          vld_q;
    logic [3:0]          err_q;
    logic                sign_q [4];
    logic [EXP_W-1:0]    exp_q [4];

    // Datapath
    logic [2*PP_W-1:0]   pp_q [9];
    logic [FRAC_W+2:0]   glue_q [2];
    logic [PROD_W-1:0]   row_q [8];
    logic [PROD_W-1:0]   lvl0_q [4];
    logic [PROD_W-1:0]   lvl1_q [2];

    assign exp_sum = {1'b0, a.exp} + {1'b0, b.exp};
    assign exp_bad = (exp_sum < (EXP_W+1)'(EXP_BIAS)) ||
                     (exp_sum > (EXP_W+1)'(EXP_MAX + EXP_BIAS));

    // ------------------------------------------------------------------
    // Control, valid and error travel together
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
            err_q <= '0;
        end else begin
            vld_q <= {vld_q[2:0], in_valid};
            err_q <= {err_q[2:0], in_valid & exp_bad};
        end
    end

    // ------------------------------------------------------------------
    // Stage 1, exponent, sign and slice products
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        exp_q[0]  <= a.exp + b.exp - EXP_W'(EXP_BIAS);
        sign_q[0] <= a.sign ^ b.sign;
        // pp index is 3*a_slice + b_slice
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                pp_q[3*i+j] <= a.frac[PP_W*i +: PP_W] * b.frac[PP_W*j +: PP_W];
            end
        end
        // Glue rows cover the hidden bit and frac bit 51 of both operands
        glue_q[0] <= {1'b1, a.frac} * {1'b1, b.frac[FRAC_W-1]};
        glue_q[1] <= b.frac[FRAC_W-2:0] * {1'b1, a.frac[FRAC_W-1]};
    end

    // ------------------------------------------------------------------
    // Stages 2 to 4, row placement and adder tree
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int s = 1; s < 4; s++) begin
            exp_q[s]  <= exp_q[s-1];
            sign_q[s] <= sign_q[s-1];
        end

        // Offsets relative to product bit 17
        row_q[0] <= PROD_W'(glue_q[0]) << (2*PP_W);
        row_q[1] <= PROD_W'(glue_q[1]) << (2*PP_W);
        row_q[2] <= PROD_W'(pp_q[0] >> PP_W) | (PROD_W'(pp_q[8]) << (3*PP_W));
        row_q[3] <= PROD_W'(pp_q[1]) | (PROD_W'(pp_q[7]) << (2*PP_W));
        row_q[4] <= PROD_W'(pp_q[3]) | (PROD_W'(pp_q[5]) << (2*PP_W));
        row_q[5] <= PROD_W'(pp_q[2]) << PP_W;
        row_q[6] <= PROD_W'(pp_q[4]) << PP_W;
        row_q[7] <= PROD_W'(pp_q[6]) << PP_W;

        // Tree levels 0 and 1
        for (int k = 0; k < 4; k++) begin
            lvl0_q[k] <= row_q[2*k] + row_q[2*k+1];
        end
        lvl1_q[0] <= lvl0_q[0] + lvl0_q[1];
        lvl1_q[1] <= lvl0_q[2] + lvl0_q[3];
    end

    assign mult.valid = vld_q[3];
    assign mult.error = err_q[3];
    assign mult.sign  = sign_q[3];
    assign mult.exp   = exp_q[3];
    assign mult.psum0 = lvl1_q[0];
    assign mult.psum1 = lvl1_q[1];

endmodule

// File: design/fma_align.sv
`timescale 1ns/100ps

module fma_align (
    input  logic                clk,
    input  logic                rst,
    input  fma_pkg::mult_out_t  mult,
    input  fma_pkg::fp64_t      c,
    output fma_pkg::align_out_t aligned
);
    import fma_pkg::*;

    // Last tree level, no register in front of the recode
    logic [PROD_W-1:0]         prod_sum;
    logic [ALIGN_W-1:0]        p_mag;
    logic [ALIGN_W-1:0]        c_mag;

    logic [1:0]                vld_q;
    logic [1:0]                err_q;

    logic signed [ALIGN_W-1:0] term_p5_q;
    logic signed [ALIGN_W-1:0] term_c5_q;
    logic [EXP_W-1:0]          exp5_q;
    logic [EXP_W-1:0]          diff_q;
    logic                      shift_c_q;

    logic signed [ALIGN_W-1:0] term_p6_q;
    logic signed [ALIGN_W-1:0] term_c6_q;
    logic [EXP_W-1:0]          exp6_q;

    assign prod_sum = mult.psum0 + mult.psum1;
    // Both magnitudes carry the hidden bit at bit 52
    assign p_mag    = {2'b00, prod_sum[PROD_W-1 -: ALIGN_W-2]};
    assign c_mag    = {4'b0001, c.frac};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
            err_q <= '0;
        end else begin
            vld_q <= {vld_q[0], mult.valid};
            err_q <= {err_q[0], mult.error};
        end
    end

    // ------------------------------------------------------------------
    // Stage 5, recode by sign and compare exponents
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        term_p5_q <= mult.sign ? -p_mag : p_mag;
        term_c5_q <= c.sign ? -c_mag : c_mag;
        if (mult.exp < c.exp) begin
            shift_c_q <= 1'b0;
            diff_q    <= c.exp - mult.exp;
            exp5_q    <= c.exp;
        end else begin
            shift_c_q <= 1'b1;
            diff_q    <= mult.exp - c.exp;
            exp5_q    <= mult.exp;
        end
    end

    // ------------------------------------------------------------------
    // Stage 6, arithmetic shift of the smaller term
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        term_p6_q <= shift_c_q ? term_p5_q : term_p5_q >>> diff_q;
        term_c6_q <= shift_c_q ? term_c5_q >>> diff_q : term_c5_q;
        exp6_q    <= exp5_q;
    end

    assign aligned.valid  = vld_q[1];
    assign aligned.error  = err_q[1];
    assign aligned.exp    = exp6_q;
    assign aligned.term_p = term_p6_q;
    assign aligned.term_c = term_c6_q;

endmodule

// File: design/fma_add_norm.sv
`timescale 1ns/100ps

module fma_add_norm (
    input  logic                clk,
    input  logic                rst,
    input  fma_pkg::align_out_t aligned,
    output fma_pkg::norm_out_t  norm
);
    import fma_pkg::*;

    // Sideband, index n is stage n+7
    logic [3:0]                vld_q;
    logic [3:0]                err_q;
    logic [EXP_W-1:0]          exp_q [3];

    logic signed [ALIGN_W-1:0] sum_q;
    logic                      sign8_q;
    logic [MAG_W-1:0]          mag8_q;
    logic [LZC_W-1:0]          lz_count;
    logic                      sign9_q;
    logic [MAG_W-1:0]          mag9_q;
    logic [LZC_W-1:0]          cnt_q;
    logic                      sign10_q;
    logic [MAG_W-1:0]          mag10_q;
    logic [EXP_W-1:0]          exp10_q;

    // Headroom of the two integer bits above the hidden bit
    logic [EXP_W:0]            exp_room;
    logic                      uflow;

    fma_lzc i_lzc (
        .mag   (mag8_q),
        .count (lz_count)
    );

    assign exp_room = {1'b0, exp_q[2]} + (EXP_W+1)'(2);
    // Zero sum also lands here
    assign uflow    = ((EXP_W+1)'(cnt_q) > exp_room) || (cnt_q == LZC_W'(MAG_W));

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
            err_q <= '0;
        end else begin
            vld_q    <= {vld_q[2:0], aligned.valid};
            err_q[0] <= aligned.error;
            err_q[1] <= err_q[0];
            err_q[2] <= err_q[1];
            // Normalize underflow only counts for a live item
            err_q[3] <= err_q[2] | (vld_q[2] & uflow);
        end
    end

    // ------------------------------------------------------------------
    // Stages 7 to 10
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        exp_q[0] <= aligned.exp;
        exp_q[1] <= exp_q[0];
        exp_q[2] <= exp_q[1];

        // Stage 7, signed add
        sum_q <= aligned.term_p + aligned.term_c;

        // Stage 8, back to sign and magnitude
        sign8_q <= sum_q[ALIGN_W-1];
        mag8_q  <= sum_q[ALIGN_W-1] ? -sum_q[MAG_W-1:0] : sum_q[MAG_W-1:0];

        // Stage 9, hold the zero count
        cnt_q   <= lz_count;
        mag9_q  <= mag8_q;
        sign9_q <= sign8_q;

        // Stage 10, leading one to the top bit
        mag10_q  <= mag9_q << cnt_q;
        exp10_q  <= EXP_W'(exp_room - (EXP_W+1)'(cnt_q));
        sign10_q <= sign9_q;
    end

    // Stage 10 exponent lives outside the shift chain
    assign norm.valid = vld_q[3];
    assign norm.error = err_q[3];
    assign norm.sign  = sign10_q;
    assign norm.exp   = exp10_q;
    assign norm.mag   = mag10_q;

endmodule

// File: design/fma_round.sv
`timescale 1ns/100ps

module fma_round (
    input  logic               clk,
    input  logic               rst,
    input  fma_pkg::norm_out_t norm,
    output fma_pkg::fp64_t     result,
    output logic               out_valid,
    output logic               error
);
    import fma_pkg::*;

    logic [FRAC_W-1:0] frac_trunc;
    logic              guard;
    logic              sticky;
    logic              round_up;
    // Extra bit catches the fraction carry-out
    logic [FRAC_W:0]   frac_rnd;
    logic [FP_W-1:0]   res_d;

    // ------------------------------------------------------------------
    // Round to nearest, ties to even
    // ------------------------------------------------------------------
    // Hidden bit is mag[54], dropped here
    assign frac_trunc = norm.mag[MAG_W-2 -: FRAC_W];
    assign guard      = norm.mag[1];
    assign sticky     = norm.mag[0];
    assign round_up   = guard & (sticky | frac_trunc[0]);
    assign frac_rnd   = {1'b0, frac_trunc} + (FRAC_W+1)'(round_up);

    // Carry-out bumps the exponent, fraction already wrapped to zero
    assign res_d = {norm.sign,
                    norm.exp + EXP_W'(frac_rnd[FRAC_W]),
                    frac_rnd[FRAC_W-1:0]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            error     <= 1'b0;
        end else begin
            out_valid <= norm.valid;
            error     <= norm.valid & norm.error;
        end
    end

    always_ff @(posedge clk) begin
        result <= res_d;
    end

endmodule

// File: design/fma_top.sv
`timescale 1ns/100ps

module fma_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  fma_pkg::fp64_t a,
    input  fma_pkg::fp64_t b,
    // Addend, sampled in the c_req cycle
    input  fma_pkg::fp64_t c,
    output logic           c_req,
    output fma_pkg::fp64_t result,
    output logic           out_valid,
    output logic           error
);
    import fma_pkg::*;

    // ------------------------------------------------------------------
    // Stage boundaries
    // ------------------------------------------------------------------
    mult_out_t  mult_w;
    align_out_t align_w;
    norm_out_t  norm_w;

    // Stages 1 to 4
    fma_mant_mult i_mant_mult (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .mult     (mult_w)
    );

    // c is due while the product sits at the stage 4 output
    assign c_req = mult_w.valid;

    // Stages 5 and 6
    fma_align i_align (
        .clk     (clk),
        .rst     (rst),
        .mult    (mult_w),
        .c       (c),
        .aligned (align_w)
    );

    // Stages 7 to 10
    fma_add_norm i_add_norm (
        .clk     (clk),
        .rst     (rst),
        .aligned (align_w),
        .norm    (norm_w)
    );

    // Stage 11
    fma_round i_round (
        .clk       (clk),
        .rst       (rst),
        .norm      (norm_w),
        .result    (result),
        .out_valid (out_valid),
        .error     (error)
    );

endmodule

// File: bench/fma_clk_gen.sv
`timescale 1ns/100ps

module fma_clk_gen (
    output logic clk,
    output logic rst
);
    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Rising edge on rst clears the pipeline before the first clock
    initial begin
        rst = 1'b0;
        #1;
        rst = 1'b1;
        repeat (10) @(posedge clk);
        // Release away from the sampling edge
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: bench/fma_sva.sv
`timescale 1ns/100ps

module fma_sva (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic c_req,
    input logic out_valid,
    input logic error
);

    // ------------------------------------------------------------------
    // Pipeline latency
    // ------------------------------------------------------------------
    // Addend request at the stage 4 output
    a_c_req_latency : assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ##4 c_req
    ) else $error("c_req did not follow in_valid by 4 cycles");

    // Result after all 11 stages
    a_out_latency : assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ##11 out_valid
    ) else $error("out_valid did not follow in_valid by 11 cycles");

    // ------------------------------------------------------------------
    // Output qualification
    // ------------------------------------------------------------------
    a_error_qualified : assert property (
        @(posedge clk) disable iff (rst) !out_valid |-> !error
    ) else $error("error high without out_valid");

    // Strobes held low in reset
    a_reset_quiet : assert property (
        @(posedge clk) rst |-> (!c_req && !out_valid)
    ) else $error("c_req or out_valid high during reset");

endmodule

bind fma_top fma_sva i_sva (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .c_req     (c_req),
    .out_valid (out_valid),
    .error     (error)
);

// File: bench/fma_tb.sv
`timescale 1ns/100ps

module fma_tb;
    import fma_pkg::*;

    localparam int WAIT_MAX   = 200;
    localparam int STREAM_LEN = 20;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            c_req;
    logic            out_valid;
    logic            error;
    fp64_t           a;
    fp64_t           b;
    fp64_t           c;
    fp64_t           result;

    // Addends wait here for c_req, expectations for out_valid
    fp64_t           c_q [$];
    logic [FP_W-1:0] exp_res_q [$];
    logic            exp_err_q [$];
    int              errors;
    int              checks;
    string           cur_test;

    fma_clk_gen i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    fma_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .c_req     (c_req),
        .result    (result),
        .out_valid (out_valid),
        .error     (error)
    );

    // ------------------------------------------------------------------
    // Value helpers
    // ------------------------------------------------------------------
    function automatic fp64_t real_to_fp64(input real r);
        return fp64_t'($realtobits(r));
    endfunction

    function automatic fp64_t pow2_fp64(input int e);
        fp64_t f;
        f.sign = 1'b0;
        f.exp  = EXP_W'(EXP_BIAS + e);
        f.frac = '0;
        return f;
    endfunction

    // Nonzero integer in -1000..1000
    function automatic int rand_operand();
        int v;
        v = int'($urandom_range(1999)) - 1000;
        if (v >= 0) begin
            v++;
        end
        return v;
    endfunction

    // ------------------------------------------------------------------
    // Background addend feed and result check
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        if (c_req) begin
            if (c_q.size() == 0) begin
                $display("c_req was raised with no addend waiting at %0t", $time);
                errors++;
                c = '0;
            end else begin
                c = c_q.pop_front();
            end
        end else begin
            c = '0;
        end
    end

    always @(negedge clk) begin : check_result
        logic [FP_W-1:0] want;
        logic            want_err;
        if (!rst && out_valid) begin
            if (exp_res_q.size() == 0) begin
                $display("out_valid was raised with no result expected at %0t", $time);
                errors++;
            end else begin
                want     = exp_res_q.pop_front();
                want_err = exp_err_q.pop_front();
                checks++;
                if (error !== want_err) begin
                    $display("ERROR [%s] error flag: expected %0b, actual %0b",
                             cur_test, want_err, error);
                    errors++;
                end
                // Result bits are undefined on an error
                if (!want_err && result !== want) begin
                    $display("ERROR [%s] result: expected %h, actual %h",
                             cur_test, want, result);
                    errors++;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Drive tasks, called right after a falling edge
    // ------------------------------------------------------------------
    task automatic push_op(input fp64_t a_v, input fp64_t b_v, input fp64_t c_v,
                           input fp64_t want, input logic want_err);
        in_valid = 1'b1;
        a        = a_v;
        b        = b_v;
        c_q.push_back(c_v);
        exp_res_q.push_back(want);
        exp_err_q.push_back(want_err);
    endtask

    // Expected value from real arithmetic
    task automatic push_int(input int x, input int y, input int z);
        push_op(real_to_fp64(real'(x)), real_to_fp64(real'(y)), real_to_fp64(real'(z)),
                real_to_fp64(real'(x) * real'(y) + real'(z)), 1'b0);
    endtask

    task automatic step();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic issue_int(input int x, input int y, input int z);
        push_int(x, y, z);
        step();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_res_q.size() != 0 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (exp_res_q.size() != 0) begin
            $display("Timed out in %s with %0d results still missing",
                     cur_test, exp_res_q.size());
            errors++;
            exp_res_q.delete();
            exp_err_q.delete();
            c_q.delete();
        end
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_latency();
        int n;
        int c_lat;
        int o_lat;
        cur_test = "reset_latency";
        n = 0;
        // Reset rises just after time zero
        do begin
            @(negedge clk);
            n++;
            if (c_req || out_valid || error) begin
                $display("Outputs were not low during reset at %0t", $time);
                errors++;
            end
        end while (rst && n < WAIT_MAX);
        if (rst) begin
            $display("Timed out waiting for reset to be released");
            errors++;
        end
        // Idle pipeline stays quiet
        repeat (5) begin
            @(negedge clk);
            if (c_req || out_valid || error) begin
                $display("Outputs went high with no operation issued at %0t", $time);
                errors++;
            end
        end
        // One operation, count falling edges to each strobe
        push_int(2, 3, 1);
        c_lat = 0;
        o_lat = 0;
        n     = 0;
        while (o_lat == 0 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
            in_valid = 1'b0;
            if (c_req && c_lat == 0) begin
                c_lat = n;
            end
            if (out_valid) begin
                o_lat = n;
            end
        end
        if (o_lat == 0) begin
            $display("Timed out waiting for out_valid of the single operation");
            errors++;
        end else begin
            if (c_lat != 4) begin
                $display("ERROR [%s] c_req latency: expected 4, actual %0d", cur_test, c_lat);
                errors++;
            end
            if (o_lat != 11) begin
                $display("ERROR [%s] out_valid latency: expected 11, actual %0d",
                         cur_test, o_lat);
                errors++;
            end
        end
        drain();
    endtask

    task automatic test_same_sign();
        cur_test = "same_sign";
        // Product exponent larger
        issue_int(12, 10, 3);
        // Addend exponent larger
        issue_int(3, 2, 100);
        issue_int(7, 9, 7);
        drain();
    endtask

    task automatic test_subtract();
        cur_test = "subtract";
        // c dominates, negative result
        issue_int(3, 5, -100);
        issue_int(-20, 6, 7);
        // Cancellation down to one, 21-bit left shift
        issue_int(1023, 1025, -1048574);
        issue_int(-1023, 1025, 1048576);
        drain();
    endtask

    task automatic test_stream();
        int x;
        int y;
        int z;
        int k;
        int n;
        int hits;
        int first;
        int last;
        cur_test = "stream";
        k     = 0;
        n     = 0;
        hits  = 0;
        first = 0;
        last  = 0;
        while (hits < STREAM_LEN && n < WAIT_MAX) begin
            if (k < STREAM_LEN) begin
                x = rand_operand();
                y = rand_operand();
                z = rand_operand();
                // Zero results are outside the supported range
                if (x * y + z == 0) begin
                    z = -z;
                end
                push_int(x, y, z);
                k++;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
            n++;
            if (out_valid) begin
                if (hits == 0) begin
                    first = n;
                end
                last = n;
                hits++;
            end
        end
        in_valid = 1'b0;
        if (hits < STREAM_LEN) begin
            $display("Timed out in stream after %0d of %0d results", hits, STREAM_LEN);
            errors++;
        end else if (last - first + 1 != STREAM_LEN) begin
            $display("ERROR [%s] out_valid span: expected %0d, actual %0d",
                     cur_test, STREAM_LEN, last - first + 1);
            errors++;
        end
        drain();
    endtask

    task automatic test_exp_error();
        cur_test = "exp_error";
        // Exponent overflow, then a clean operation behind it
        push_op(pow2_fp64(600), pow2_fp64(600), real_to_fp64(1.0), '0, 1'b1);
        step();
        issue_int(2, 3, 4);
        // Exponent underflow
        push_op(pow2_fp64(-600), pow2_fp64(-600), real_to_fp64(1.0), '0, 1'b1);
        step();
        issue_int(5, 5, 5);
        drain();
    endtask

    // ------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------
    task automatic finish_run();
        $display("Checked %0d results, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        c         = '0;
        cur_test  = "init";
        void'($urandom(54));
        test_reset_latency();
        test_same_sign();
        test_subtract();
        test_stream();
        test_exp_error();
        finish_run();
    end

    // Hard limit on the whole run
    initial begin
        #100000;
        $display("Simulation time limit reached before the tests completed");
        errors++;
        finish_run();
    end

endmodule

// File: sources.f
design/fma_pkg.sv
design/fma_lzc.sv
design/fma_mant_mult.sv
design/fma_align.sv
design/fma_add_norm.sv
design/fma_round.sv
design/fma_top.sv
bench/fma_clk_gen.sv
bench/fma_sva.sv
bench/fma_tb.sv

// File: Bender.yml
package:
  name: fma

sources:
  # Design, package first
  - design/fma_pkg.sv
  - design/fma_lzc.sv
  - design/fma_mant_mult.sv
  - design/fma_align.sv
  - design/fma_add_norm.sv
  - design/fma_round.sv
  - design/fma_top.sv

  # Bench, assertions bound into fma_top
  - target: test
    files:
      - bench/fma_clk_gen.sv
      - bench/fma_sva.sv
      - bench/fma_tb.sv
